/* rtl/fp_params.svh */
`ifndef FP_PARAMS_SVH
`define FP_PARAMS_SVH

////////////////////////////////////////////////////////////
// adc side
////////////////////////////////////////////////////////////

`define FP_N_ADC 6 // active adc channels
`define FP_W_ADC 18 // raw sample width

////////////////////////////////////////////////////////////
// oversample filter and output preprocessor
////////////////////////////////////////////////////////////

`define FP_W_OSF_CD 16 // cycle delay
`define FP_W_OSF_LOG 6 // log2 of oversample ratio
`define FP_N_OPP 3 // output preprocessor channels
`define FP_N_OPP_EN 4 // opp update enable bits

////////////////////////////////////////////////////////////
// host bus
////////////////////////////////////////////////////////////

`define FP_W_HOST 16 // host data word
`define FP_EP_WOUT_BASE 8'h20 // first adc wire-out

`endif

/* rtl/fp_host_pkg.sv */
package fp_host_pkg;

	`include "fp_params.svh"

	// one bus request per cycle, wr and rd never together
	typedef struct packed {
		logic                   wr;
		logic                   rd;
		logic [7:0]             addr;
		logic [`FP_W_HOST-1:0]  wdata;
	} host_req_t;

	// read answer, one cycle after rd
	typedef struct packed {
		logic                   rvalid;
		logic [`FP_W_HOST-1:0]  rdata;
	} host_rsp_t;

	// endpoint address map
	typedef enum logic [7:0] {
		// wire-ins
		EP_ADC_OS = 8'h01, EP_OSF_CYCLE_DELAY = 8'h02, EP_OSF_OVR = 8'h03,
		EP_OSF_UPDATE_EN = 8'h04, EP_PID_SETPOINT = 8'h05, EP_PID_P = 8'h06,
		EP_PID_I = 8'h07, EP_PID_D = 8'h08, EP_PID_UPDATE_EN = 8'h09,
		EP_RTR_SRC = 8'h0A, EP_RTR_DEST = 8'h0B,
		EP_OPP_INIT0 = 8'h0C, EP_OPP_INIT1 = 8'h0D, EP_OPP_INIT2 = 8'h0E,
		EP_OPP_MIN0 = 8'h0F, EP_OPP_MIN1 = 8'h10, EP_OPP_MIN2 = 8'h11,
		EP_OPP_MAX0 = 8'h12, EP_OPP_MAX1 = 8'h13, EP_OPP_MAX2 = 8'h14,
		EP_OPP_UPDATE_EN = 8'h15, EP_OSF_ACTIVATE = 8'h16,
		// wire-outs, truncated adc samples
		EP_WOUT_0 = `FP_EP_WOUT_BASE,
		EP_WOUT_1 = `FP_EP_WOUT_BASE + 8'h01,
		EP_WOUT_2 = `FP_EP_WOUT_BASE + 8'h02,
		EP_WOUT_3 = `FP_EP_WOUT_BASE + 8'h03,
		EP_WOUT_4 = `FP_EP_WOUT_BASE + 8'h04,
		EP_WOUT_5 = `FP_EP_WOUT_BASE + 8'h05,
		// trigger-ins
		EP_TRIG_ADC_CSTART = 8'h53, EP_TRIG_PID_CLEAR = 8'h55,
		EP_TRIG_DAC_REF = 8'h56, EP_TRIG_MODULE_UPDATE = 8'h57,
		EP_TRIG_SYS_RESET = 8'h58
	} fp_ep_e;

endpackage

/* rtl/fp_ctrl_pkg.sv */
package fp_ctrl_pkg;

	`include "fp_params.svh"

	////////////////////////////////////////////////////////////
	// config going out to the processing chain
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [2:0] os; // adc oversampling pins
	} adc_cfg_t;

	typedef struct packed {
		logic [`FP_N_ADC-1:0]      activate;
		logic [`FP_W_OSF_CD-1:0]   cycle_delay;
		logic [`FP_W_OSF_LOG-1:0]  log_ovr; // derived, not written directly
		logic [`FP_N_ADC-1:0]      update_en;
	} osf_cfg_t;

	typedef struct packed {
		logic [`FP_W_HOST-1:0]         setpoint;
		logic signed [`FP_W_HOST-1:0]  p_coef;
		logic signed [`FP_W_HOST-1:0]  i_coef;
		logic signed [`FP_W_HOST-1:0]  d_coef;
		logic [`FP_N_ADC-1:0]          update_en;
	} pid_cfg_t;

	typedef struct packed {
		logic [3:0] src_sel;
		logic [3:0] dest_sel;
	} rtr_cfg_t;

	// word 0 sits in the low 16 bits
	typedef struct packed {
		logic [`FP_N_OPP*`FP_W_HOST-1:0]  min;
		logic [`FP_N_OPP*`FP_W_HOST-1:0]  max;
		logic [`FP_N_OPP*`FP_W_HOST-1:0]  init;
		logic [`FP_N_OPP_EN-1:0]          update_en;
	} opp_cfg_t;

	// single cycle command pulses
	typedef struct packed {
		logic                  adc_cstart;
		logic [`FP_N_ADC-1:0]  pid_clear; // one per channel
		logic                  dac_ref_set;
		logic                  module_update;
		logic                  sys_reset;
	} fp_trig_t;

	// latest sample of every channel
	typedef logic [`FP_N_ADC-1:0][`FP_W_ADC-1:0] adc_chan_t;

endpackage

/* rtl/fp_adc_capture.sv */
`timescale 1ns/1ps

`include "fp_params.svh"

module fp_adc_capture
	import fp_ctrl_pkg::*;
(
	input  logic                  clk50_in,
	input  logic                  arst_n,

	// from adc controller
	input  logic [`FP_N_ADC-1:0]  adc_valid,
	input  logic [`FP_W_ADC-1:0]  adc_data_a, // lower half of the channels
	input  logic [`FP_W_ADC-1:0]  adc_data_b, // upper half of the channels

	// to the read-back mux
	output adc_chan_t             adc_chan
);

	localparam int N_PAIR = `FP_N_ADC / 2;

	////////////////////////////////////////////////////////////
	// sample registers
	////////////////////////////////////////////////////////////

	adc_chan_t chan_q;

	// channel i and i+N_PAIR share one slot in time,
	// the a-bus wins when both valids are up
	for (genvar i = 0; i < N_PAIR; i++) begin : g_pair
		logic load_a;
		logic load_b;

		assign load_a = adc_valid[i];
		assign load_b = adc_valid[i+N_PAIR] & ~adc_valid[i];

		always_ff @(posedge clk50_in or negedge arst_n) begin
			if (!arst_n) begin
				chan_q[i] <= '0;
			end else if (load_a) begin
				chan_q[i] <= adc_data_a;
			end
		end

		always_ff @(posedge clk50_in or negedge arst_n) begin
			if (!arst_n) begin
				chan_q[i+N_PAIR] <= '0;
			end else if (load_b) begin
				chan_q[i+N_PAIR] <= adc_data_b;
			end
		end
	end

	assign adc_chan = chan_q; // visible the cycle after valid

endmodule

/* rtl/fp_host_endpoints.sv */
`timescale 1ns/1ps

`include "fp_params.svh"

module fp_host_endpoints
	import fp_host_pkg::*;
	import fp_ctrl_pkg::*;
(
	input  logic       clk50_in,
	input  logic       arst_n,
	input  host_req_t  host_req,
	input  adc_chan_t  adc_chan,
	output host_rsp_t  host_rsp,
	output adc_cfg_t   adc_cfg,
	output osf_cfg_t   osf_cfg,
	output pid_cfg_t   pid_cfg,
	output rtr_cfg_t   rtr_cfg,
	output opp_cfg_t   opp_cfg
);

	localparam int W_SEL = $clog2(`FP_N_ADC);

	// index of the highest set bit, 0 for an empty word
	function automatic logic [`FP_W_OSF_LOG-1:0] hsb_index(input logic [`FP_W_HOST-1:0] v);
		logic [`FP_W_OSF_LOG-1:0] idx;
		idx = '0;
		for (int b = 0; b < `FP_W_HOST; b++) begin
			if (v[b]) idx = `FP_W_OSF_LOG'(b); // last hit is the highest
		end
		return idx;
	endfunction

	////////////////////////////////////////////////////////////
	// wire-in register bank
	////////////////////////////////////////////////////////////

	logic [`FP_W_HOST-1:0]     wi_q [EP_ADC_OS:EP_OSF_ACTIVATE];
	logic [`FP_W_OSF_LOG-1:0]  log_ovr_q;
	logic                      wi_hit;

	assign wi_hit = host_req.wr && (host_req.addr >= EP_ADC_OS) &&
		(host_req.addr <= EP_OSF_ACTIVATE);

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = EP_ADC_OS; k <= EP_OSF_ACTIVATE; k++) wi_q[k] <= '0;
			log_ovr_q <= '0;
		end else begin
			if (wi_hit) wi_q[host_req.addr] <= host_req.wdata;
			if (host_req.wr && host_req.addr == EP_OSF_OVR) begin
				log_ovr_q <= hsb_index(host_req.wdata); // same edge as the raw value
			end
		end
	end

	// config fields are the low bits of each word
	always_comb begin
		adc_cfg.os = wi_q[EP_ADC_OS][2:0];

		osf_cfg.activate    = wi_q[EP_OSF_ACTIVATE][`FP_N_ADC-1:0];
		osf_cfg.cycle_delay = wi_q[EP_OSF_CYCLE_DELAY][`FP_W_OSF_CD-1:0];
		osf_cfg.log_ovr     = log_ovr_q;
		osf_cfg.update_en   = wi_q[EP_OSF_UPDATE_EN][`FP_N_ADC-1:0];

		pid_cfg.setpoint  = wi_q[EP_PID_SETPOINT];
		pid_cfg.p_coef    = $signed(wi_q[EP_PID_P]);
		pid_cfg.i_coef    = $signed(wi_q[EP_PID_I]);
		pid_cfg.d_coef    = $signed(wi_q[EP_PID_D]);
		pid_cfg.update_en = wi_q[EP_PID_UPDATE_EN][`FP_N_ADC-1:0];

		rtr_cfg.src_sel  = wi_q[EP_RTR_SRC][3:0];
		rtr_cfg.dest_sel = wi_q[EP_RTR_DEST][3:0];

		for (int k = 0; k < `FP_N_OPP; k++) begin
			opp_cfg.min[k*`FP_W_HOST +: `FP_W_HOST]  = wi_q[EP_OPP_MIN0 + k];
			opp_cfg.max[k*`FP_W_HOST +: `FP_W_HOST]  = wi_q[EP_OPP_MAX0 + k];
			opp_cfg.init[k*`FP_W_HOST +: `FP_W_HOST] = wi_q[EP_OPP_INIT0 + k];
		end
		opp_cfg.update_en = wi_q[EP_OPP_UPDATE_EN][`FP_N_OPP_EN-1:0];
	end

	////////////////////////////////////////////////////////////
	// read-back
	////////////////////////////////////////////////////////////

	logic [W_SEL-1:0]       wout_sel;
	logic [`FP_W_HOST-1:0]  rd_data;

	assign wout_sel = W_SEL'(host_req.addr - `FP_EP_WOUT_BASE);

	always_comb begin
		case (host_req.addr) inside
			[EP_ADC_OS:EP_OSF_ACTIVATE]: rd_data = wi_q[host_req.addr];
			[EP_WOUT_0:EP_WOUT_5]: rd_data = adc_chan[wout_sel][`FP_W_ADC-1 -: `FP_W_HOST];
			default: rd_data = '0; // triggers and holes
		endcase
	end

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			host_rsp <= '0;
		end else begin
			host_rsp.rvalid <= host_req.rd;
			host_rsp.rdata  <= host_req.rd ? rd_data : '0;
		end
	end

endmodule

/* rtl/fp_trigger_in.sv */
`timescale 1ns/1ps

module fp_trigger_in
	import fp_host_pkg::*;
	import fp_ctrl_pkg::*;
(
	input  logic       clk50_in,
	input  logic       arst_n,
	input  host_req_t  host_req,
	output fp_trig_t   trig
);

	fp_trig_t trig_d;
	fp_trig_t trig_q;

	////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////

	// only bits the field actually has are taken
	always_comb begin
		trig_d = '0;
		if (host_req.wr) begin
			case (host_req.addr)
				EP_TRIG_ADC_CSTART: begin
					trig_d.adc_cstart = host_req.wdata[0];
				end
				EP_TRIG_PID_CLEAR: begin
					trig_d.pid_clear = host_req.wdata[$bits(trig_d.pid_clear)-1:0];
				end
				EP_TRIG_DAC_REF: begin
					trig_d.dac_ref_set = host_req.wdata[0];
				end
				EP_TRIG_MODULE_UPDATE: begin
					trig_d.module_update = host_req.wdata[0];
				end
				EP_TRIG_SYS_RESET: begin
					trig_d.sys_reset = host_req.wdata[0];
				end
				default: trig_d = '0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// pulse register
	////////////////////////////////////////////////////////////

	// reloaded every cycle so a pulse clears on its own
	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			trig_q <= '0;
		end else begin
			trig_q <= trig_d;
		end
	end

	assign trig = trig_q;

endmodule

/* rtl/frontpanel_interface.sv */
`timescale 1ns/1ps

`include "fp_params.svh"

module frontpanel_interface
	import fp_host_pkg::*;
	import fp_ctrl_pkg::*;
(
	input  logic                  clk50_in,
	input  logic                  arst_n,

	// host register bus
	input  host_req_t             host_req,
	output host_rsp_t             host_rsp,

	// from adc controller
	input  logic [`FP_N_ADC-1:0]  adc_valid,
	input  logic [`FP_W_ADC-1:0]  adc_data_a,
	input  logic [`FP_W_ADC-1:0]  adc_data_b,

	// config to the processing chain
	output adc_cfg_t              adc_cfg,
	output osf_cfg_t              osf_cfg,
	output pid_cfg_t              pid_cfg,
	output rtr_cfg_t              rtr_cfg,
	output opp_cfg_t              opp_cfg,

	// command pulses
	output fp_trig_t              trig
);

	adc_chan_t adc_chan; // capture -> read-back

	////////////////////////////////////////////////////////////
	// adc sample capture
	////////////////////////////////////////////////////////////

	fp_adc_capture capture_i (
		.clk50_in   (clk50_in),
		.arst_n     (arst_n),
		.adc_valid  (adc_valid),
		.adc_data_a (adc_data_a),
		.adc_data_b (adc_data_b),
		.adc_chan   (adc_chan)
	);

	////////////////////////////////////////////////////////////
	// wire-ins and wire-outs
	////////////////////////////////////////////////////////////

	fp_host_endpoints endpoints_i (
		.clk50_in (clk50_in),
		.arst_n   (arst_n),
		.host_req (host_req),
		.adc_chan (adc_chan),
		.host_rsp (host_rsp),
		.adc_cfg  (adc_cfg),
		.osf_cfg  (osf_cfg),
		.pid_cfg  (pid_cfg),
		.rtr_cfg  (rtr_cfg),
		.opp_cfg  (opp_cfg)
	);

	////////////////////////////////////////////////////////////
	// trigger-ins
	////////////////////////////////////////////////////////////

	fp_trigger_in trigger_i (
		.clk50_in (clk50_in),
		.arst_n   (arst_n),
		.host_req (host_req), // same request, separate decode
		.trig     (trig)
	);

endmodule

/* verif/frontpanel_assert.sv */
`timescale 1ns/1ps

module frontpanel_assert
	import fp_host_pkg::*;
	import fp_ctrl_pkg::*;
(
	input logic       clk50_in,
	input logic       arst_n,
	input host_req_t  host_req,
	input host_rsp_t  host_rsp,
	input adc_cfg_t   adc_cfg,
	input osf_cfg_t   osf_cfg,
	input pid_cfg_t   pid_cfg,
	input rtr_cfg_t   rtr_cfg,
	input opp_cfg_t   opp_cfg,
	input fp_trig_t   trig
);

	logic [$bits(fp_trig_t)-1:0] trig_bits;

	assign trig_bits = trig;

	rsp_one_cycle: assert property (@(posedge clk50_in) disable iff (!arst_n)
		host_rsp.rvalid == $past(host_req.rd)) else $error("rvalid does not follow rd");

	trig_single: assert property (@(posedge clk50_in) disable iff (!arst_n)
		(trig_bits & $past(trig_bits)) == '0) else $error("trigger high for two cycles");

	trig_after_wr: assert property (@(posedge clk50_in) disable iff (!arst_n)
		|trig_bits |-> $past(host_req.wr)) else $error("trigger pulse without a write");

	// every output held at zero while in reset
	reset_quiet: assert property (@(posedge clk50_in)
		!arst_n |-> {host_rsp, trig_bits, adc_cfg, osf_cfg, pid_cfg, rtr_cfg, opp_cfg} == '0)
		else $error("output not cleared in reset");

endmodule

bind frontpanel_interface frontpanel_assert assert_i (.*);

/* verif/tb_frontpanel.sv */
`timescale 1ns/1ps

`include "fp_params.svh"

module tb_frontpanel
	import fp_host_pkg::*;
	import fp_ctrl_pkg::*;
();

	localparam int n_wr    = 300; // random wire-in writes
	localparam int n_ovr   = 100;
	localparam int n_trig  = 150;
	localparam int n_adc   = 500;
	localparam int n_other = 40;
	// each write is followed by a read-back or an idle cycle
	localparam int planned_cycles = 2 + 22 + 2*(n_wr + n_ovr + n_trig) + n_adc + n_other + 1;
	localparam int timeout_cycles = 2 * planned_cycles;

	logic                  clk50_in;
	logic                  arst_n;
	host_req_t             host_req;
	host_rsp_t             host_rsp;
	logic [`FP_N_ADC-1:0]  adc_valid;
	logic [`FP_W_ADC-1:0]  adc_data_a;
	logic [`FP_W_ADC-1:0]  adc_data_b;
	adc_cfg_t              adc_cfg;
	osf_cfg_t              osf_cfg;
	pid_cfg_t              pid_cfg;
	rtr_cfg_t              rtr_cfg;
	opp_cfg_t              opp_cfg;
	fp_trig_t              trig;

	// reference model state
	logic [`FP_W_HOST-1:0]     wi_m [0:255] = '{default: '0};
	logic [`FP_W_ADC-1:0]      chan_m [0:`FP_N_ADC-1] = '{default: '0};
	logic [`FP_W_OSF_LOG-1:0]  log_m = '0;
	fp_trig_t                  trig_exp = '0;
	host_rsp_t                 rsp_exp = '0;

	int n_checks = 0;
	int n_errors = 0;
	int cycle_count = 0;

	frontpanel_interface dut_i (.*);

	initial clk50_in = 1'b0;
	always #50 clk50_in = ~clk50_in; // 100 ns period

	always @(posedge clk50_in) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			$display("timeout, the run did not finish within %0d cycles", timeout_cycles);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic [`FP_W_OSF_LOG-1:0] top_bit_index(input logic [`FP_W_HOST-1:0] v);
		for (int b = `FP_W_HOST-1; b > 0; b--) begin
			if (v[b]) begin
				return `FP_W_OSF_LOG'(b);
			end
		end
		return '0; // bit 0 alone or empty word
	endfunction

	function automatic logic [`FP_W_HOST-1:0] read_value(input logic [7:0] addr);
		if (addr >= EP_ADC_OS && addr <= EP_OSF_ACTIVATE) begin
			return wi_m[addr];
		end else if (addr >= `FP_EP_WOUT_BASE && addr < `FP_EP_WOUT_BASE + `FP_N_ADC) begin
			return chan_m[addr - `FP_EP_WOUT_BASE][`FP_W_ADC-1:2]; // upper 16 of 18
		end
		return '0;
	endfunction

	function automatic fp_trig_t trig_for(input host_req_t req);
		fp_trig_t t;
		t = '0;
		if (req.wr) begin
			case (req.addr)
				EP_TRIG_ADC_CSTART:    t.adc_cstart    = req.wdata[0];
				EP_TRIG_PID_CLEAR:     t.pid_clear     = req.wdata[`FP_N_ADC-1:0];
				EP_TRIG_DAC_REF:       t.dac_ref_set   = req.wdata[0];
				EP_TRIG_MODULE_UPDATE: t.module_update = req.wdata[0];
				EP_TRIG_SYS_RESET:     t.sys_reset     = req.wdata[0];
				default:               t = '0;
			endcase
		end
		return t;
	endfunction

	// runs at the clock edge, before the tb changes any input
	task automatic update_model();
		rsp_exp.rvalid = host_req.rd;
		rsp_exp.rdata  = host_req.rd ? read_value(host_req.addr) : '0;
		trig_exp       = trig_for(host_req);
		if (host_req.wr && host_req.addr >= EP_ADC_OS && host_req.addr <= EP_OSF_ACTIVATE) begin
			wi_m[host_req.addr] = host_req.wdata;
		end
		if (host_req.wr && host_req.addr == EP_OSF_OVR) begin
			log_m = top_bit_index(host_req.wdata);
		end
		for (int i = 0; i < `FP_N_ADC/2; i++) begin
			if (adc_valid[i]) begin
				chan_m[i] = adc_data_a; // a-bus wins the pair
			end else if (adc_valid[i+`FP_N_ADC/2]) begin
				chan_m[i+`FP_N_ADC/2] = adc_data_b;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// checks and bus access
	////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [159:0] exp, input logic [159:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic check_outputs();
		compare("adc_cfg", 160'(wi_m[EP_ADC_OS][2:0]), 160'(adc_cfg));
		compare("osf_cfg", 160'({wi_m[EP_OSF_ACTIVATE][`FP_N_ADC-1:0], wi_m[EP_OSF_CYCLE_DELAY],
			log_m, wi_m[EP_OSF_UPDATE_EN][`FP_N_ADC-1:0]}), 160'(osf_cfg));
		compare("osf_cfg.log_ovr", 160'(log_m), 160'(osf_cfg.log_ovr));
		compare("pid_cfg", 160'({wi_m[EP_PID_SETPOINT], wi_m[EP_PID_P], wi_m[EP_PID_I],
			wi_m[EP_PID_D], wi_m[EP_PID_UPDATE_EN][`FP_N_ADC-1:0]}), 160'(pid_cfg));
		compare("rtr_cfg", 160'({wi_m[EP_RTR_SRC][3:0], wi_m[EP_RTR_DEST][3:0]}), 160'(rtr_cfg));
		compare("opp_cfg", 160'({wi_m[EP_OPP_MIN2], wi_m[EP_OPP_MIN1], wi_m[EP_OPP_MIN0],
			wi_m[EP_OPP_MAX2], wi_m[EP_OPP_MAX1], wi_m[EP_OPP_MAX0],
			wi_m[EP_OPP_INIT2], wi_m[EP_OPP_INIT1], wi_m[EP_OPP_INIT0],
			wi_m[EP_OPP_UPDATE_EN][`FP_N_OPP_EN-1:0]}), 160'(opp_cfg));
		compare("trig", 160'(trig_exp), 160'(trig));
		if (host_rsp.rvalid !== rsp_exp.rvalid) begin
			n_errors++;
			if (rsp_exp.rvalid) begin
				$display("read issued one cycle before %0d ns got no response", $time);
			end else begin
				$display("response at %0d ns arrived without a read", $time);
			end
		end else if (rsp_exp.rvalid) begin
			compare("host_rsp.rdata", 160'(rsp_exp.rdata), 160'(host_rsp.rdata));
		end
	endtask

	// one bus cycle, called 5 ns after a rising edge
	task automatic bus_op(input logic wr, input logic rd, input logic [7:0] addr,
		input logic [`FP_W_HOST-1:0] wdata);
		host_req = '{wr: wr, rd: rd, addr: addr, wdata: wdata};
		@(negedge clk50_in);
		check_outputs(); // outputs settled since the last edge
		@(posedge clk50_in);
		update_model();
		#5;
		host_req  = '0;
		adc_valid = '0;
	endtask

	initial begin
		logic [7:0]            addr;
		logic [`FP_W_HOST-1:0] data;

		void'($urandom(32'h4adf_ab0b));
		arst_n     = 1'b0;
		host_req   = '0;
		adc_valid  = '0;
		adc_data_a = '0;
		adc_data_b = '0;
		repeat (2) @(posedge clk50_in);
		#5 arst_n = 1'b1;

		for (int a = EP_ADC_OS; a <= EP_OSF_ACTIVATE; a++) begin
			bus_op(1'b0, 1'b1, 8'(a), '0); // reset values
		end

		repeat (n_wr) begin
			addr = 8'($urandom_range(EP_OSF_ACTIVATE, EP_ADC_OS));
			bus_op(1'b1, 1'b0, addr, `FP_W_HOST'($urandom()));
			bus_op(1'b0, 1'b1, addr, '0);
		end

		// ratios of every magnitude, zero included
		repeat (n_ovr) begin
			data = `FP_W_HOST'($urandom() >> $urandom_range(32, 16));
			bus_op(1'b1, 1'b0, EP_OSF_OVR, data);
			bus_op(1'b0, 1'b1, EP_OSF_OVR, '0);
		end

		// 0x54 is a hole in the trigger range and must stay quiet
		repeat (n_trig) begin
			addr = EP_TRIG_ADC_CSTART + 8'($urandom_range(5, 0));
			bus_op(1'b1, 1'b0, addr, `FP_W_HOST'($urandom()));
			bus_op(1'b0, 1'b0, '0, '0);
		end

		for (int k = 0; k < n_adc; k++) begin
			adc_valid  = `FP_N_ADC'($urandom());
			adc_data_a = `FP_W_ADC'($urandom());
			adc_data_b = `FP_W_ADC'($urandom());
			addr = `FP_EP_WOUT_BASE + 8'($urandom_range(`FP_N_ADC-1, 0));
			bus_op(1'b0, k % 2 == 0, addr, '0);
		end

		for (int k = 0; k < n_other; k++) begin
			case (k % 3)
				0: addr = 8'($urandom_range(8'h1F, 8'h17));
				1: addr = 8'($urandom_range(8'h58, 8'h53));
				default: addr = 8'($urandom_range(255, 8'h26));
			endcase
			bus_op(1'b0, 1'b1, (k == 0) ? 8'h00 : addr, '0);
		end
		bus_op(1'b0, 1'b0, '0, '0); // last response

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+rtl
rtl/fp_host_pkg.sv
rtl/fp_ctrl_pkg.sv
rtl/fp_adc_capture.sv
rtl/fp_host_endpoints.sv
rtl/fp_trigger_in.sv
rtl/frontpanel_interface.sv
verif/frontpanel_assert.sv
verif/tb_frontpanel.sv

/* run_sim.sh */
#!/bin/sh
# build and run tb_frontpanel with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_frontpanel \
	-Mdir obj_dir -o tb_frontpanel
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_frontpanel > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit 1
fi

if grep -q "Test failed" "$log"; then
	exit 1
fi
exit 0
